/* project.f */
+incdir+test
hw/glb_pkg.sv
hw/glb_bank.sv
hw/glb_host_port.sv
hw/glb_cfg_regs.sv
hw/glb_stream_fsm.sv
hw/glb_addr_counter.sv
hw/glb_tile.sv
test/glb_tile_tb.sv

/* Makefile */
# Verilator simulation of the global buffer tile testbench

VERILATOR ?= verilator
TOP       ?= glb_tile_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= FAIL: see errors above
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)_sim
	./$(BUILD_DIR)/$(TOP)_sim > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/glb_tile_tb_util.svh */
/*
 * Testbench helpers: LFSR random bits, value compare, failure notes, idle wait.
 * Included inside glb_tile_tb after its signal and counter declarations.
 */
`ifndef GLB_TILE_TB_UTIL_SVH
`define GLB_TILE_TB_UTIL_SVH

// Fibonacci LFSR, taps 16 14 13 11, one step per bit taken
function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        fb        = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        v         = {v[62:0], fb};
    end
    return v;
endfunction

task automatic check_value(input string name, input logic [63:0] got,
                           input logic [63:0] expected);
    if (got !== expected) begin
        $display("ERROR: %s got 0x%h expected 0x%h at %0t", name, got, expected, $time);
        mismatch_count++;
    end
endtask

task automatic note_failure(input string msg);
    $display("%s (at %0t)", msg, $time);
    failure_count++;
endtask

// Polls the status register until the stream engine is idle
task automatic wait_for_idle(input int timeout);
    int n;
    n = 0;
    glb_config_rd   = 1'b1;
    glb_config_addr = cfg_addr(TILE_ID, CFG_REG_STATUS);
    #4;
    while (glb_config_rd_data != '0 && n < timeout) begin
        @(posedge clk);
        #4;
        n++;
    end
    if (glb_config_rd_data != '0) begin
        note_failure($sformatf("Timeout: tile still busy after %0d cycles", timeout));
    end
    glb_config_rd = 1'b0;
    @(posedge clk);
    #1;
endtask

`endif

/* test/glb_tile_tb.sv */
/*
 * Testbench for glb_tile with tile id 5. Memory and descriptor model in the bench.
 * Inputs change 1 ns after each rising edge and outputs are sampled there too.
 */
`timescale 1ns/1ps

module glb_tile_tb;
    import glb_pkg::*;

    localparam logic [TILE_ID_WIDTH-1:0] TILE_ID = 4'd5;
    localparam int NUM_WORDS = NUM_BANKS << BANK_ADDR_WIDTH;

    logic                       clk;
    logic                       arst_n;
    logic                       clk_en;
    host_wr_t                   host_wr;
    host_rd_t                   host_rd;
    logic [BANK_DATA_WIDTH-1:0] host_rd_data;
    logic                       glb_config_wr;
    logic                       glb_config_rd;
    logic [CFG_ADDR_WIDTH-1:0]  glb_config_addr;
    logic [CFG_DATA_WIDTH-1:0]  glb_config_wr_data;
    logic [CFG_DATA_WIDTH-1:0]  glb_config_rd_data;
    logic                       cgra_start_pulse;
    logic                       cgra_done_pulse;
    logic [BANK_DATA_WIDTH-1:0] stream_data;
    logic                       stream_valid;

    // Reference model
    logic [BANK_DATA_WIDTH-1:0] model_mem [NUM_WORDS];
    logic [STREAM_ADDR_WIDTH:0] model_start;
    logic [STREAM_ADDR_WIDTH:0] model_count;

    logic [15:0] lfsr_state = 16'd34;
    int          mismatch_count = 0;
    int          failure_count = 0;

    function automatic logic [CFG_ADDR_WIDTH-1:0] cfg_addr(input logic [3:0] tile,
                                                           input logic [1:0] idx);
        return {tile, idx, 2'b00};
    endfunction

    `include "glb_tile_tb_util.svh"

    glb_tile UUT (
        .clk                (clk),
        .arst_n             (arst_n),
        .clk_en             (clk_en),
        .glb_tile_id        (TILE_ID),
        .host_wr            (host_wr),
        .host_rd            (host_rd),
        .host_rd_data       (host_rd_data),
        .glb_config_wr      (glb_config_wr),
        .glb_config_rd      (glb_config_rd),
        .glb_config_addr    (glb_config_addr),
        .glb_config_wr_data (glb_config_wr_data),
        .glb_config_rd_data (glb_config_rd_data),
        .cgra_start_pulse   (cgra_start_pulse),
        .cgra_done_pulse    (cgra_done_pulse),
        .stream_data        (stream_data),
        .stream_valid       (stream_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic host_write(input logic [GLB_ADDR_WIDTH-1:0] addr,
                              input logic [BANK_STRB_WIDTH-1:0] strb,
                              input logic [BANK_DATA_WIDTH-1:0] data);
        logic [STREAM_ADDR_WIDTH-1:0] w;
        w = addr[GLB_ADDR_WIDTH-1:BYTE_OFFSET_WIDTH];
        for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
            if (strb[b]) begin
                model_mem[w][b*8 +: 8] = data[b*8 +: 8];
            end
        end
        host_wr = '{en: 1'b1, strb: strb, addr: addr, data: data};
        @(posedge clk);
        #1;
        host_wr.en = 1'b0;
    endtask

    // Word is valid one edge after the bank read
    task automatic host_read_check(input logic [GLB_ADDR_WIDTH-1:0] addr);
        host_rd = '{en: 1'b1, addr: addr};
        @(posedge clk);
        #1;
        host_rd.en = 1'b0;
        @(posedge clk);
        #1;
        check_value("host_rd_data", host_rd_data,
                    model_mem[addr[GLB_ADDR_WIDTH-1:BYTE_OFFSET_WIDTH]]);
    endtask

    task automatic cfg_write(input logic [3:0] tile, input logic [1:0] idx,
                             input logic [CFG_DATA_WIDTH-1:0] data);
        if (tile == TILE_ID && idx == CFG_REG_START) begin
            model_start = data[STREAM_ADDR_WIDTH:0];
        end
        if (tile == TILE_ID && idx == CFG_REG_COUNT) begin
            model_count = data[STREAM_ADDR_WIDTH:0];
        end
        glb_config_wr      = 1'b1;
        glb_config_addr    = cfg_addr(tile, idx);
        glb_config_wr_data = data;
        @(posedge clk);
        #1;
        glb_config_wr = 1'b0;
    endtask

    task automatic cfg_read_check(input logic [3:0] tile, input logic [1:0] idx,
                                  input logic [CFG_DATA_WIDTH-1:0] expected);
        glb_config_rd   = 1'b1;
        glb_config_addr = cfg_addr(tile, idx);
        #4;
        check_value("glb_config_rd_data", 64'(glb_config_rd_data), 64'(expected));
        @(posedge clk);
        #1;
        glb_config_rd = 1'b0;
    endtask

    task automatic run_stream(input logic [STREAM_ADDR_WIDTH:0] start,
                              input logic [STREAM_ADDR_WIDTH:0] count,
                              input bit stall, input bit restart);
        int                           cycles;
        int                           n_words;
        int                           last_valid;
        int                           limit;
        bit                           done_seen;
        bit                           prev_en;
        logic [STREAM_ADDR_WIDTH-1:0] word;
        wait_for_idle(20);
        cfg_write(TILE_ID, CFG_REG_START, 32'(start));
        cfg_write(TILE_ID, CFG_REG_COUNT, 32'(count));
        // Status stays on the read bus for the whole stream
        glb_config_rd    = 1'b1;
        glb_config_addr  = cfg_addr(TILE_ID, CFG_REG_STATUS);
        cgra_start_pulse = 1'b1;
        clk_en           = 1'b1;
        cycles     = 0;
        n_words    = 0;
        last_valid = 0;
        done_seen  = 1'b0;
        prev_en    = 1'b1;
        limit      = 32'(count) * 6 + 20;
        while (!done_seen && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
            if (stream_valid) begin
                if (!prev_en) begin
                    note_failure("A stream word appeared right after a stalled cycle");
                end
                word = start[STREAM_ADDR_WIDTH-1:0] + STREAM_ADDR_WIDTH'(n_words);
                check_value("stream_data", stream_data, model_mem[word]);
                n_words++;
                last_valid = cycles;
            end
            if (cgra_done_pulse) begin
                done_seen = 1'b1;
                if (count == '0) begin
                    check_value("done_cycle", 64'(cycles), 64'd2);
                end else begin
                    check_value("done_cycle", 64'(cycles), 64'(last_valid + 1));
                end
            end
            check_value("status", 64'(glb_config_rd_data), done_seen ? 64'd0 : 64'd1);
            cgra_start_pulse = restart && (cycles == 2);
            prev_en          = stall ? rand_bits(1) : 1'b1;
            clk_en           = prev_en;
        end
        if (!done_seen) begin
            note_failure($sformatf("Timeout: no cgra_done_pulse within %0d cycles", limit));
        end
        @(posedge clk);
        #1;
        check_value("cgra_done_pulse", 64'(cgra_done_pulse), 64'd0);
        check_value("stream_valid", 64'(stream_valid), 64'd0);
        check_value("stream_word_count", 64'(n_words), 64'(count));
        clk_en           = 1'b1;
        cgra_start_pulse = 1'b0;
        glb_config_rd    = 1'b0;
    endtask

    initial begin
        logic [3:0]                 other_tile;
        logic [STREAM_ADDR_WIDTH:0] held_start;
        logic [STREAM_ADDR_WIDTH:0] held_count;
        logic [BANK_STRB_WIDTH-1:0] strb;
        arst_n             = 1'b0;
        clk_en             = 1'b1;
        host_wr            = '0;
        host_rd            = '0;
        glb_config_wr      = 1'b0;
        glb_config_rd      = 1'b0;
        glb_config_addr    = '0;
        glb_config_wr_data = '0;
        cgra_start_pulse   = 1'b0;
        model_start        = '0;
        model_count        = '0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Reset state
        check_value("stream_valid", 64'(stream_valid), 64'd0);
        check_value("cgra_done_pulse", 64'(cgra_done_pulse), 64'd0);
        cfg_read_check(TILE_ID, CFG_REG_START, 32'd0);
        cfg_read_check(TILE_ID, CFG_REG_COUNT, 32'd0);
        cfg_read_check(TILE_ID, CFG_REG_STATUS, 32'd0);

        // Full-word fill, then strobed writes and random reads
        for (int w = 0; w < NUM_WORDS; w++) begin
            host_write({9'(w), 3'(rand_bits(3))}, 8'hff, rand_bits(64));
        end
        for (int i = 0; i < 64; i++) begin
            strb = 8'(rand_bits(8));
            if (strb == '0) begin
                strb = 8'h01;
            end
            host_write(12'(rand_bits(12)), strb, rand_bits(64));
        end
        for (int i = 0; i < 64; i++) begin
            host_read_check(12'(rand_bits(12)));
        end

        // Configuration access, own tile and foreign tile
        cfg_write(TILE_ID, CFG_REG_START, 32'(rand_bits(10)));
        cfg_write(TILE_ID, CFG_REG_COUNT, 32'(rand_bits(10)));
        cfg_read_check(TILE_ID, CFG_REG_START, 32'(model_start));
        cfg_read_check(TILE_ID, CFG_REG_COUNT, 32'(model_count));
        held_start = model_start;
        held_count = model_count;
        other_tile = TILE_ID + 4'd1 + 4'(rand_bits(3));
        cfg_write(other_tile, CFG_REG_START, 32'(rand_bits(10)));
        cfg_write(other_tile, CFG_REG_COUNT, 32'(rand_bits(10)));
        cfg_write(TILE_ID, CFG_REG_STATUS, 32'hffff_ffff);
        cfg_read_check(TILE_ID, CFG_REG_START, 32'(held_start));
        cfg_read_check(TILE_ID, CFG_REG_COUNT, 32'(held_count));
        cfg_read_check(other_tile, CFG_REG_START, 32'd0);
        cfg_read_check(other_tile, CFG_REG_COUNT, 32'd0);
        cfg_read_check(TILE_ID, CFG_REG_STATUS, 32'd0);

        // Bank crossing, wrap, empty and single-word streams
        run_stream(10'd250, 10'd12, 1'b0, 1'b0);
        run_stream(10'd505, 10'd10, 1'b0, 1'b0);
        run_stream(10'd17, 10'd0, 1'b0, 1'b0);
        run_stream(10'(rand_bits(9)), 10'd1, 1'b0, 1'b0);
        for (int i = 0; i < 6; i++) begin
            run_stream(10'(rand_bits(9)), 10'd1 + 10'(rand_bits(5)), 1'b1, 1'b0);
        end
        for (int i = 0; i < 2; i++) begin
            run_stream(10'(rand_bits(9)), 10'd4 + 10'(rand_bits(4)), 1'b0, 1'b1);
        end
        run_stream(10'(rand_bits(9)), 10'd12, 1'b1, 1'b1);

        $display("Mismatches: %0d, other failures: %0d", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* hw/glb_tile.sv */
/*
 * Global buffer tile: host port, SRAM banks, descriptor registers, stream engine.
 * No neighbor chaining and no fabric writes.
 */
`timescale 1ns/1ps

module glb_tile (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                clk_en,
    input  logic [glb_pkg::TILE_ID_WIDTH-1:0]   glb_tile_id,

    // Host
    input  glb_pkg::host_wr_t                   host_wr,
    input  glb_pkg::host_rd_t                   host_rd,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] host_rd_data,

    // Config
    input  logic                                glb_config_wr,
    input  logic                                glb_config_rd,
    input  logic [glb_pkg::CFG_ADDR_WIDTH-1:0]  glb_config_addr,
    input  logic [glb_pkg::CFG_DATA_WIDTH-1:0]  glb_config_wr_data,
    output logic [glb_pkg::CFG_DATA_WIDTH-1:0]  glb_config_rd_data,

    // Stream to fabric
    input  logic                                cgra_start_pulse,
    output logic                                cgra_done_pulse,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] stream_data,
    output logic                                stream_valid
);
    import glb_pkg::*;

    bank_wr_t                   bank_wr [NUM_BANKS];
    bank_rd_t                   bank_rd [NUM_BANKS];
    logic [BANK_DATA_WIDTH-1:0] bank_rd_data [NUM_BANKS];
    bank_rd_t                   bank_stream_rd [NUM_BANKS];
    logic [BANK_DATA_WIDTH-1:0] bank_stream_data [NUM_BANKS];

    stream_desc_t              desc;
    bank_rd_t                  stream_rd;
    logic [BANK_SEL_WIDTH-1:0] bank_sel;
    logic [BANK_SEL_WIDTH-1:0] stream_sel_q;
    logic                      load;
    logic                      step;
    logic                      last;
    logic                      busy;

    glb_host_port u_host_port (
        .clk          (clk),
        .arst_n       (arst_n),
        .host_wr      (host_wr),
        .host_rd      (host_rd),
        .host_rd_data (host_rd_data),
        .bank_wr      (bank_wr),
        .bank_rd      (bank_rd),
        .bank_rd_data (bank_rd_data)
    );

    // Stream request goes only to the bank holding the current word
    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            bank_stream_rd[i].en   = stream_rd.en && (bank_sel == BANK_SEL_WIDTH'(i));
            bank_stream_rd[i].addr = stream_rd.addr;
        end
    end

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        glb_bank u_bank (
            .clk            (clk),
            .arst_n         (arst_n),
            .host_wr        (bank_wr[i]),
            .host_rd        (bank_rd[i]),
            .host_rd_data   (bank_rd_data[i]),
            .stream_rd      (bank_stream_rd[i]),
            .stream_rd_data (bank_stream_data[i])
        );
    end

    // Bank of the last issued stream read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stream_sel_q <= '0;
        end else if (stream_rd.en) begin
            stream_sel_q <= bank_sel;
        end
    end

    assign stream_data = bank_stream_data[stream_sel_q];

    glb_cfg_regs u_cfg_regs (
        .clk                (clk),
        .arst_n             (arst_n),
        .glb_tile_id        (glb_tile_id),
        .glb_config_wr      (glb_config_wr),
        .glb_config_rd      (glb_config_rd),
        .glb_config_addr    (glb_config_addr),
        .glb_config_wr_data (glb_config_wr_data),
        .glb_config_rd_data (glb_config_rd_data),
        .busy               (busy),
        .desc               (desc)
    );

    glb_stream_fsm u_stream_fsm (
        .clk              (clk),
        .arst_n           (arst_n),
        .clk_en           (clk_en),
        .cgra_start_pulse (cgra_start_pulse),
        .last             (last),
        .load             (load),
        .step             (step),
        .stream_valid     (stream_valid),
        .cgra_done_pulse  (cgra_done_pulse),
        .busy             (busy)
    );

    glb_addr_counter u_addr_counter (
        .clk       (clk),
        .arst_n    (arst_n),
        .load      (load),
        .step      (step),
        .desc      (desc),
        .stream_rd (stream_rd),
        .bank_sel  (bank_sel),
        .last      (last)
    );

endmodule

/* hw/glb_addr_counter.sv */
/*
 * Stream word address and remaining count. Address wraps within the tile.
 * A start address wider than the tile is truncated.
 */
`timescale 1ns/1ps

module glb_addr_counter (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                load,
    input  logic                                step,
    input  glb_pkg::stream_desc_t               desc,
    output glb_pkg::bank_rd_t                   stream_rd,
    output logic [glb_pkg::BANK_SEL_WIDTH-1:0]  bank_sel,
    output logic                                last
);
    import glb_pkg::*;

    logic [STREAM_ADDR_WIDTH-1:0] addr_q;
    logic [STREAM_ADDR_WIDTH:0]   remain_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            addr_q   <= '0;
            remain_q <= '0;
        end else if (load) begin
            addr_q   <= desc.start_addr[STREAM_ADDR_WIDTH-1:0];
            remain_q <= desc.count;
        end else if (step) begin
            addr_q   <= addr_q + 1'b1;
            remain_q <= remain_q - 1'b1;
        end
    end

    assign stream_rd.en   = step;
    assign stream_rd.addr = addr_q[BANK_ADDR_WIDTH-1:0];
    assign bank_sel       = addr_q[BANK_ADDR_WIDTH +: BANK_SEL_WIDTH];

    // On load the FSM needs to know whether the stream is empty
    assign last = load ? (desc.count == '0) : (remain_q <= 1);

    // A read is issued only while words remain, so never outside a stream
    a_no_step_when_empty: assert property (
        @(posedge clk) disable iff (!arst_n) step |-> (remain_q != '0)
    );

endmodule

/* hw/glb_stream_fsm.sv */
/*
 * Stream control FSM with IDLE, RUN and FINISH states.
 * Start is taken only in IDLE with clk_en high.
 * Done follows the last valid word by one cycle, or the start by two when empty.
 */
`timescale 1ns/1ps

module glb_stream_fsm (
    input  logic clk,
    input  logic arst_n,
    input  logic clk_en,
    input  logic cgra_start_pulse,
    input  logic last,
    output logic load,
    output logic step,
    output logic stream_valid,
    output logic cgra_done_pulse,
    output logic busy
);
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FINISH
    } state_t;

    state_t state;
    state_t state_next;

    // Last flags an empty descriptor during a load
    always_comb begin
        state_next = state;
        load       = 1'b0;
        case (state)
            IDLE: begin
                if (clk_en && cgra_start_pulse) begin
                    load       = 1'b1;
                    state_next = last ? FINISH : RUN;
                end
            end
            RUN: begin
                if (clk_en && last) begin
                    state_next = FINISH;
                end
            end
            // Final valid word drains here regardless of clk_en
            FINISH:  state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    assign step = (state == RUN) && clk_en;
    assign busy = (state != IDLE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state           <= IDLE;
            stream_valid    <= 1'b0;
            cgra_done_pulse <= 1'b0;
        end else begin
            state           <= state_next;
            stream_valid    <= step;
            cgra_done_pulse <= (state == FINISH);
        end
    end

    a_done_single: assert property (
        @(posedge clk) disable iff (!arst_n) cgra_done_pulse |=> !cgra_done_pulse
    );

endmodule

/* hw/glb_cfg_regs.sv */
/*
 * Stream descriptor registers on the tile-addressed configuration bus.
 * Reads are combinational and return zero when not addressed to this tile.
 */
`timescale 1ns/1ps

module glb_cfg_regs (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic [glb_pkg::TILE_ID_WIDTH-1:0]  glb_tile_id,
    input  logic                               glb_config_wr,
    input  logic                               glb_config_rd,
    input  logic [glb_pkg::CFG_ADDR_WIDTH-1:0] glb_config_addr,
    input  logic [glb_pkg::CFG_DATA_WIDTH-1:0] glb_config_wr_data,
    output logic [glb_pkg::CFG_DATA_WIDTH-1:0] glb_config_rd_data,
    input  logic                               busy,
    output glb_pkg::stream_desc_t              desc
);
    import glb_pkg::*;

    localparam int DESC_FIELD_WIDTH = STREAM_ADDR_WIDTH + 1;

    logic [TILE_ID_WIDTH-1:0]     tile_field;
    logic [CFG_REG_IDX_WIDTH-1:0] reg_idx;
    logic                         tile_hit;
    logic                         cfg_wr;
    logic                         cfg_rd;

    assign tile_field = glb_config_addr[CFG_TILE_LSB +: TILE_ID_WIDTH];
    assign reg_idx    = glb_config_addr[CFG_BYTE_OFFSET_WIDTH +: CFG_REG_IDX_WIDTH];
    assign tile_hit   = (tile_field == glb_tile_id);
    assign cfg_wr     = tile_hit && glb_config_wr;
    assign cfg_rd     = tile_hit && glb_config_rd;

    // Status is read only, so only start and count take writes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            desc <= '0;
        end else if (cfg_wr) begin
            if (reg_idx == CFG_REG_START) begin
                desc.start_addr <= glb_config_wr_data[DESC_FIELD_WIDTH-1:0];
            end
            if (reg_idx == CFG_REG_COUNT) begin
                desc.count <= glb_config_wr_data[DESC_FIELD_WIDTH-1:0];
            end
        end
    end

    always_comb begin
        glb_config_rd_data = '0;
        if (cfg_rd) begin
            case (reg_idx)
                CFG_REG_START:  glb_config_rd_data = CFG_DATA_WIDTH'(desc.start_addr);
                CFG_REG_COUNT:  glb_config_rd_data = CFG_DATA_WIDTH'(desc.count);
                CFG_REG_STATUS: glb_config_rd_data = CFG_DATA_WIDTH'(busy);
                default:        glb_config_rd_data = '0;
            endcase
        end
    end

endmodule

/* hw/glb_host_port.sv */
/*
 * Host byte address to bank request decode. The byte offset is dropped.
 * Read word is valid one cycle after the bank read and held until the next.
 */
`timescale 1ns/1ps

module glb_host_port (
    input  logic                                clk,
    input  logic                                arst_n,
    input  glb_pkg::host_wr_t                   host_wr,
    input  glb_pkg::host_rd_t                   host_rd,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] host_rd_data,
    output glb_pkg::bank_wr_t                   bank_wr [glb_pkg::NUM_BANKS],
    output glb_pkg::bank_rd_t                   bank_rd [glb_pkg::NUM_BANKS],
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] bank_rd_data [glb_pkg::NUM_BANKS]
);
    import glb_pkg::*;

    localparam int SEL_LSB = BYTE_OFFSET_WIDTH + BANK_ADDR_WIDTH;

    logic [BANK_SEL_WIDTH-1:0] wr_sel;
    logic [BANK_SEL_WIDTH-1:0] rd_sel;
    logic [BANK_SEL_WIDTH-1:0] rd_sel_q;
    logic                      rd_pend_q;

    assign wr_sel = host_wr.addr[SEL_LSB +: BANK_SEL_WIDTH];
    assign rd_sel = host_rd.addr[SEL_LSB +: BANK_SEL_WIDTH];

    // Only the selected bank sees an enable
    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            bank_wr[i].en   = host_wr.en && (wr_sel == BANK_SEL_WIDTH'(i));
            bank_wr[i].strb = host_wr.strb;
            bank_wr[i].addr = host_wr.addr[BYTE_OFFSET_WIDTH +: BANK_ADDR_WIDTH];
            bank_wr[i].data = host_wr.data;
            bank_rd[i].en   = host_rd.en && (rd_sel == BANK_SEL_WIDTH'(i));
            bank_rd[i].addr = host_rd.addr[BYTE_OFFSET_WIDTH +: BANK_ADDR_WIDTH];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_pend_q <= 1'b0;
            rd_sel_q  <= '0;
        end else begin
            rd_pend_q <= host_rd.en;
            if (host_rd.en) begin
                rd_sel_q <= rd_sel;
            end
        end
    end

    // Capture the returned word of the bank read one cycle earlier
    always_ff @(posedge clk) begin
        if (rd_pend_q) begin
            host_rd_data <= bank_rd_data[rd_sel_q];
        end
    end

endmodule

/* hw/glb_bank.sv */
/*
 * One SRAM bank: strobed host write, registered host and stream reads.
 * A host write and a stream read of the same word in one cycle is undefined.
 */
`timescale 1ns/1ps

module glb_bank (
    input  logic                                clk,
    input  logic                                arst_n,
    input  glb_pkg::bank_wr_t                   host_wr,
    input  glb_pkg::bank_rd_t                   host_rd,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] host_rd_data,
    input  glb_pkg::bank_rd_t                   stream_rd,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] stream_rd_data
);
    import glb_pkg::*;

    localparam int DEPTH = 1 << BANK_ADDR_WIDTH;

    logic [BANK_DATA_WIDTH-1:0] mem [DEPTH];

    // Byte lanes written only where the strobe is set
    always_ff @(posedge clk) begin
        if (host_wr.en) begin
            for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
                if (host_wr.strb[b]) begin
                    mem[host_wr.addr][b*8 +: 8] <= host_wr.data[b*8 +: 8];
                end
            end
        end
    end

    // Both read ports hold their word until the next read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            host_rd_data   <= '0;
            stream_rd_data <= '0;
        end else begin
            if (host_rd.en) begin
                host_rd_data <= mem[host_rd.addr];
            end
            if (stream_rd.en) begin
                stream_rd_data <= mem[stream_rd.addr];
            end
        end
    end

    // Host side must never issue an empty write
    a_wr_strb_nonzero: assert property (
        @(posedge clk) disable iff (!arst_n) host_wr.en |-> (host_wr.strb != '0)
    );

endmodule

/* hw/glb_pkg.sv */
/*
 * Shared widths and request structs for one global buffer tile.
 * Two banks of 256 words of 64 bits each. Host addresses are byte addresses.
 */
package glb_pkg;

    // Bank geometry
    localparam int NUM_BANKS         = 2;
    localparam int BANK_DATA_WIDTH   = 64;
    localparam int BANK_STRB_WIDTH   = BANK_DATA_WIDTH / 8;
    localparam int BANK_ADDR_WIDTH   = 8;
    localparam int BANK_SEL_WIDTH    = 1;
    localparam int BYTE_OFFSET_WIDTH = 3;

    // Host byte address, low to high: byte offset, word address, bank select
    localparam int GLB_ADDR_WIDTH = BYTE_OFFSET_WIDTH + BANK_ADDR_WIDTH + BANK_SEL_WIDTH;

    // Configuration bus, tile field in [7:4] and register index in [3:2]
    localparam int TILE_ID_WIDTH         = 4;
    localparam int CFG_ADDR_WIDTH        = 8;
    localparam int CFG_DATA_WIDTH        = 32;
    localparam int CFG_BYTE_OFFSET_WIDTH = 2;
    localparam int CFG_REG_IDX_WIDTH     = 2;
    localparam int CFG_TILE_LSB          = CFG_BYTE_OFFSET_WIDTH + CFG_REG_IDX_WIDTH;

    localparam logic [CFG_REG_IDX_WIDTH-1:0] CFG_REG_START  = 2'd0;
    localparam logic [CFG_REG_IDX_WIDTH-1:0] CFG_REG_COUNT  = 2'd1;
    localparam logic [CFG_REG_IDX_WIDTH-1:0] CFG_REG_STATUS = 2'd2;

    // Word address across the tile, bank select above the word address
    localparam int STREAM_ADDR_WIDTH = BANK_SEL_WIDTH + BANK_ADDR_WIDTH;

    typedef struct packed {
        logic                       en;
        logic [BANK_STRB_WIDTH-1:0] strb;
        logic [GLB_ADDR_WIDTH-1:0]  addr;
        logic [BANK_DATA_WIDTH-1:0] data;
    } host_wr_t;

    typedef struct packed {
        logic                      en;
        logic [GLB_ADDR_WIDTH-1:0] addr;
    } host_rd_t;

    typedef struct packed {
        logic                       en;
        logic [BANK_STRB_WIDTH-1:0] strb;
        logic [BANK_ADDR_WIDTH-1:0] addr;
        logic [BANK_DATA_WIDTH-1:0] data;
    } bank_wr_t;

    typedef struct packed {
        logic                       en;
        logic [BANK_ADDR_WIDTH-1:0] addr;
    } bank_rd_t;

    // Count of zero means an empty stream
    typedef struct packed {
        logic [STREAM_ADDR_WIDTH:0] start_addr;
        logic [STREAM_ADDR_WIDTH:0] count;
    } stream_desc_t;

endpackage
